// ==== design/sdcmd_pkg.sv ====
/*
 * Widths, constants, record types and the execute FSM encoding for the
 * SD command-line controller. Every design unit imports it with a wildcard.
 */
package sdcmd_pkg;

    // Frame geometry on the CMD line
    localparam int FRAME_BITS  = 48;
    localparam int HEADER_BITS = 40;
    // Response window, counted in clocks after the command end bit
    localparam int NCR_MIN     = 2;
    localparam int RSP_TIMEOUT = 64;
    // Request buffer depth equals the credits a requester owns after reset
    localparam int REQ_CREDITS = 2;
    localparam int RSP_CREDITS = 2;
    // Result queue depth
    localparam int RSP_DEPTH   = 2;
    // Derived counter and pointer widths
    localparam int REQ_PTR_W   = $clog2(REQ_CREDITS);
    localparam int REQ_CNT_W   = $clog2(REQ_CREDITS + 1);
    localparam int RSP_PTR_W   = $clog2(RSP_DEPTH);
    localparam int RSP_CNT_W   = $clog2(RSP_DEPTH + 1);
    localparam int CRD_W       = $clog2(RSP_CREDITS + 1);
    localparam int CNT_W       = $clog2(RSP_TIMEOUT + 1);

    typedef logic [5:0]             cmd_index_t;
    typedef logic [31:0]            cmd_arg_t;
    typedef logic [6:0]             crc7_t;
    typedef logic [HEADER_BITS-1:0] cmd_header_t;
    typedef logic [FRAME_BITS-1:0]  cmd_frame_t;

    typedef struct packed {
        cmd_index_t index;
        cmd_arg_t   arg;
        logic       expect_rsp;
    } cmd_req_t;

    // Header as it goes on the line, index kept for matching the echo
    typedef struct packed {
        cmd_header_t bits;
        logic        expect_rsp;
        cmd_index_t  index;
    } cmd_hdr_t;

    typedef struct packed {
        cmd_frame_t frame;
        crc7_t      crc;
        cmd_index_t index;
        logic       timeout;
        logic       no_rsp;
    } rsp_raw_t;

    typedef struct packed {
        cmd_index_t index;
        cmd_arg_t   status;
        logic       no_rsp;
        logic       timeout;
        logic       crc_err;
        logic       frame_err;
        logic       index_err;
    } cmd_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        SEND,
        CRC_OUT,
        TURN,
        WAIT_START,
        RECV,
        HAND_OFF
    } line_state_t;

endpackage

// ==== design/sdcmd_crc7.sv ====
/*
 * Serial CRC7 generator, polynomial x^7 + x^3 + 1, one bit per strobe.
 * The output is the value after the bit now being fed, so the caller can
 * capture the finished CRC in the same cycle as the last data bit.
 */
module sdcmd_crc7
    import sdcmd_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_nrst,
    input  logic  i_clear,
    input  logic  i_next,
    input  logic  i_dat,
    output crc7_t o_crc7
);

    crc7_t crc_q;
    crc7_t crc_d;
    logic  fb;

    // Outgoing MSB mixed with the new bit feeds taps 0 and 3
    assign fb = crc_q[6] ^ i_dat;
    assign crc_d = {crc_q[5:3], crc_q[2] ^ fb, crc_q[1:0], fb};

    // Lookahead value for the current bit
    assign o_crc7 = crc_d;

    // Clear wins over next when both are strobed
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            crc_q <= '0;
        end else if (i_clear) begin
            crc_q <= '0;
        end else if (i_next) begin
            crc_q <= crc_d;
        end
    end

endmodule

// ==== design/sdcmd_decode.sv ====
/*
 * Request buffer in front of the line engine. Holds up to REQ_CREDITS
 * commands, presents the head entry as a 40-bit frame header and returns
 * one requester credit for every entry that execute takes.
 */
module sdcmd_decode
    import sdcmd_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_nrst,
    input  logic     i_req_valid,
    input  cmd_req_t i_req,
    input  logic     i_hdr_take,
    output logic     o_hdr_valid,
    output cmd_hdr_t o_hdr,
    output logic     o_req_credit
);

    cmd_req_t             buf_mem [REQ_CREDITS];
    logic [REQ_PTR_W-1:0] wr_ptr;
    logic [REQ_PTR_W-1:0] rd_ptr;
    logic [REQ_CNT_W-1:0] count;
    logic                 do_take;
    cmd_req_t             head;

    assign o_hdr_valid = (count != '0);
    assign do_take = i_hdr_take & o_hdr_valid;

    // Credit goes back in the same cycle the slot is freed
    assign o_req_credit = do_take;

    assign head = buf_mem[rd_ptr];

    // Start bit 0 and transmission bit 1 lead the index and argument
    always_comb begin
        o_hdr.bits = {1'b0, 1'b1, head.index, head.arg};
        o_hdr.expect_rsp = head.expect_rsp;
        o_hdr.index = head.index;
    end

    // Storage only, the requester never writes without a credit
    always_ff @(posedge i_clk) begin
        if (i_req_valid) begin
            buf_mem[wr_ptr] <= i_req;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (i_req_valid) begin
                wr_ptr <= (wr_ptr == REQ_PTR_W'(REQ_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_take) begin
                rd_ptr <= (rd_ptr == REQ_PTR_W'(REQ_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Occupancy follows the write and take strobes
            case ({i_req_valid, do_take})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== design/sdcmd_line_engine.sv ====
/*
 * Execute stage. Sends each header MSB first with its CRC7 and end bit,
 * then optionally waits for and samples a 48-bit response. One shift
 * register and the single CRC block serve both directions.
 */
module sdcmd_line_engine
    import sdcmd_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_nrst,
    input  logic     i_hdr_valid,
    input  cmd_hdr_t i_hdr,
    output logic     o_hdr_take,
    input  logic     i_slot_free,
    output logic     o_cmd_out,
    output logic     o_cmd_oe,
    input  logic     i_cmd_in,
    output logic     o_crc_clear,
    output logic     o_crc_next,
    output logic     o_crc_dat,
    input  crc7_t    i_crc,
    output logic     o_raw_valid,
    output rsp_raw_t o_raw
);

    line_state_t      state;
    logic [CNT_W-1:0] cnt;
    cmd_frame_t       sh;
    crc7_t            rx_crc;
    cmd_index_t       idx_q;
    logic             expect_q;
    logic             timeout_q;

    // A frame is only started when result has room for its record
    assign o_hdr_take = (state == IDLE) && i_hdr_valid && i_slot_free;

    // Line is driven for the 40 header bits plus CRC and end bit
    assign o_cmd_oe = (state == SEND) || (state == CRC_OUT);
    assign o_cmd_out = o_cmd_oe ? sh[FRAME_BITS-1] : 1'b1;

    always_comb begin
        o_crc_clear = 1'b0;
        o_crc_next = 1'b0;
        o_crc_dat = 1'b0;
        case (state)
            // CRC is zeroed before the transmit and receive phases
            IDLE, TURN: begin
                o_crc_clear = 1'b1;
            end
            SEND: begin
                o_crc_next = 1'b1;
                o_crc_dat = sh[FRAME_BITS-1];
            end
            // Only the start bit itself is fed while waiting
            WAIT_START: begin
                o_crc_next = ~i_cmd_in;
                o_crc_dat = i_cmd_in;
            end
            // The first 40 received bits are covered by the CRC
            RECV: begin
                o_crc_next = (cnt < CNT_W'(HEADER_BITS));
                o_crc_dat = i_cmd_in;
            end
            default: begin
                o_crc_clear = 1'b0;
            end
        endcase
    end

    assign o_raw_valid = (state == HAND_OFF);

    always_comb begin
        o_raw.frame = sh;
        o_raw.crc = rx_crc;
        o_raw.index = idx_q;
        o_raw.timeout = timeout_q;
        o_raw.no_rsp = ~expect_q;
    end

    // Control path
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state <= IDLE;
            cnt <= '0;
            expect_q <= 1'b0;
            timeout_q <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (o_hdr_take) begin
                        state <= SEND;
                        cnt <= '0;
                        expect_q <= i_hdr.expect_rsp;
                        timeout_q <= 1'b0;
                    end
                end
                SEND: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(HEADER_BITS - 1)) begin
                        state <= CRC_OUT;
                        cnt <= '0;
                    end
                end
                // Seven CRC bits and the end bit
                CRC_OUT: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(FRAME_BITS - HEADER_BITS - 1)) begin
                        state <= expect_q ? TURN : HAND_OFF;
                        cnt <= '0;
                    end
                end
                // Timer runs from the first clock after the end bit
                TURN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(NCR_MIN - 1)) begin
                        state <= WAIT_START;
                    end
                end
                WAIT_START: begin
                    cnt <= cnt + 1'b1;
                    if (!i_cmd_in) begin
                        // Start bit counts as the first sampled bit
                        state <= RECV;
                        cnt <= CNT_W'(1);
                    end else if (cnt == CNT_W'(RSP_TIMEOUT - 1)) begin
                        state <= HAND_OFF;
                        timeout_q <= 1'b1;
                    end
                end
                RECV: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(FRAME_BITS - 1)) begin
                        state <= HAND_OFF;
                    end
                end
                HAND_OFF: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Shift register and captured fields
    always_ff @(posedge i_clk) begin
        case (state)
            IDLE: begin
                if (o_hdr_take) begin
                    sh <= {i_hdr.bits, {(FRAME_BITS - HEADER_BITS){1'b1}}};
                    idx_q <= i_hdr.index;
                end
            end
            SEND: begin
                // Lookahead CRC is final while the 40th bit is fed
                if (cnt == CNT_W'(HEADER_BITS - 1)) begin
                    sh <= {i_crc, 1'b1, {(FRAME_BITS - 8){1'b1}}};
                end else begin
                    sh <= {sh[FRAME_BITS-2:0], 1'b1};
                end
            end
            CRC_OUT: begin
                sh <= {sh[FRAME_BITS-2:0], 1'b1};
            end
            WAIT_START: begin
                if (!i_cmd_in) begin
                    sh <= {sh[FRAME_BITS-2:0], i_cmd_in};
                end
            end
            RECV: begin
                sh <= {sh[FRAME_BITS-2:0], i_cmd_in};
                if (cnt == CNT_W'(HEADER_BITS - 1)) begin
                    rx_crc <= i_crc;
                end
            end
            default: begin
                sh <= sh;
            end
        endcase
    end

endmodule

// ==== design/sdcmd_result.sv ====
/*
 * Result stage. Checks framing, index echo and CRC of each raw response,
 * queues up to RSP_DEPTH records in command order and sends them to the
 * consumer only while it holds result credits.
 */
module sdcmd_result
    import sdcmd_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_nrst,
    input  logic     i_raw_valid,
    input  rsp_raw_t i_raw,
    output logic     o_slot_free,
    output logic     o_rsp_valid,
    output cmd_rsp_t o_rsp,
    input  logic     i_rsp_credit
);

    cmd_rsp_t             q_mem [RSP_DEPTH];
    cmd_rsp_t             rec;
    logic [RSP_PTR_W-1:0] wr_ptr;
    logic [RSP_PTR_W-1:0] rd_ptr;
    logic [RSP_CNT_W-1:0] count;
    logic [CRD_W-1:0]     credits;
    logic                 send;
    logic                 silent;

    // Nothing was received when the card timed out or no reply was asked
    assign silent = i_raw.timeout | i_raw.no_rsp;

    // Field positions within the sampled 48-bit frame
    always_comb begin
        rec.index = i_raw.index;
        rec.no_rsp = i_raw.no_rsp;
        rec.timeout = i_raw.timeout;
        rec.status = silent ? '0 : i_raw.frame[FRAME_BITS-HEADER_BITS +: $bits(cmd_arg_t)];
        rec.frame_err = ~silent & (i_raw.frame[FRAME_BITS-2] | ~i_raw.frame[0]);
        rec.index_err = ~silent &
            (i_raw.frame[FRAME_BITS-3 -: $bits(cmd_index_t)] != i_raw.index);
        rec.crc_err = ~silent & (i_raw.frame[1 +: $bits(crc7_t)] != i_raw.crc);
    end

    // Execute only starts a frame while a slot is free
    assign o_slot_free = (count != RSP_CNT_W'(RSP_DEPTH));

    assign send = (count != '0) && (credits != '0);
    assign o_rsp_valid = send;
    assign o_rsp = q_mem[rd_ptr];

    always_ff @(posedge i_clk) begin
        if (i_raw_valid) begin
            q_mem[wr_ptr] <= rec;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            credits <= CRD_W'(RSP_CREDITS);
        end else begin
            if (i_raw_valid) begin
                wr_ptr <= (wr_ptr == RSP_PTR_W'(RSP_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= (rd_ptr == RSP_PTR_W'(RSP_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({i_raw_valid, send})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit spent per record, one returned per consumer pulse
            case ({send, i_rsp_credit})
                2'b10: credits <= credits - 1'b1;
                2'b01: credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

// ==== design/sdcmd_top.sv ====
/*
 * Top level of the SD command-line controller. Connects the request
 * buffer, the line engine with its shared CRC7 block, and the result stage.
 */
module sdcmd_top
    import sdcmd_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_nrst,
    input  logic     i_req_valid,
    input  cmd_req_t i_req,
    output logic     o_req_credit,
    output logic     o_rsp_valid,
    output cmd_rsp_t o_rsp,
    input  logic     i_rsp_credit,
    output logic     o_cmd_out,
    output logic     o_cmd_oe,
    input  logic     i_cmd_in
);

    logic     hdr_valid;
    cmd_hdr_t hdr;
    logic     hdr_take;
    logic     slot_free;
    logic     crc_clear;
    logic     crc_next;
    logic     crc_dat;
    crc7_t    crc_value;
    logic     raw_valid;
    rsp_raw_t raw;

    sdcmd_decode u_decode (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_req_valid  (i_req_valid),
        .i_req        (i_req),
        .i_hdr_take   (hdr_take),
        .o_hdr_valid  (hdr_valid),
        .o_hdr        (hdr),
        .o_req_credit (o_req_credit)
    );

    // Single CRC block shared by transmit and receive
    sdcmd_crc7 u_crc7 (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_clear (crc_clear),
        .i_next  (crc_next),
        .i_dat   (crc_dat),
        .o_crc7  (crc_value)
    );

    sdcmd_line_engine u_line_engine (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_hdr_valid (hdr_valid),
        .i_hdr       (hdr),
        .o_hdr_take  (hdr_take),
        .i_slot_free (slot_free),
        .o_cmd_out   (o_cmd_out),
        .o_cmd_oe    (o_cmd_oe),
        .i_cmd_in    (i_cmd_in),
        .o_crc_clear (crc_clear),
        .o_crc_next  (crc_next),
        .o_crc_dat   (crc_dat),
        .i_crc       (crc_value),
        .o_raw_valid (raw_valid),
        .o_raw       (raw)
    );

    sdcmd_result u_result (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_raw_valid  (raw_valid),
        .i_raw        (raw),
        .o_slot_free  (slot_free),
        .o_rsp_valid  (o_rsp_valid),
        .o_rsp        (o_rsp),
        .i_rsp_credit (i_rsp_credit)
    );

endmodule

// ==== verif/sdcmd_tb.sv ====
/*
 * Self-checking testbench for the SD command-line controller. A requester
 * spends credits, a card model checks each frame and answers it, and a
 * consumer compares the result records and returns credits.
 */
module sdcmd_tb
    import sdcmd_pkg::*;
();

    localparam int NUM_CMDS     = 40;
    localparam int CYCLE_LIMIT  = NUM_CMDS * 200;
    localparam int HOLD_CYCLES  = 600;
    localparam logic [31:0] SEED = 32'h80b9;
    // Card behavior per command
    localparam int MODE_GOOD    = 0;
    localparam int MODE_BAD_CRC = 1;
    localparam int MODE_BAD_END = 2;
    localparam int MODE_BAD_IDX = 3;
    localparam int MODE_SILENT  = 4;
    localparam int MODE_NO_RSP  = 5;

    logic     i_clk;
    logic     i_nrst;
    logic     i_req_valid;
    cmd_req_t i_req;
    logic     o_req_credit;
    logic     o_rsp_valid;
    cmd_rsp_t o_rsp;
    logic     i_rsp_credit;
    logic     o_cmd_out;
    logic     o_cmd_oe;
    logic     i_cmd_in;

    cmd_req_t    cmd_list [NUM_CMDS];
    int          mode_list [NUM_CMDS];
    cmd_rsp_t    exp_q [$];
    logic [31:0] rng_req;
    logic [31:0] rng_card;
    logic [31:0] rng_cons;
    int          checks = 0;
    int          errors = 0;
    int          cycles = 0;
    int          sent = 0;
    int          req_credits = REQ_CREDITS;
    int          rsp_count = 0;
    int          dut_rsp_credits = RSP_CREDITS;
    int          owed_credits = 0;
    int          hold_left = HOLD_CYCLES;

    sdcmd_top sdcmd_top_i (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_req_valid  (i_req_valid),
        .i_req        (i_req),
        .o_req_credit (o_req_credit),
        .o_rsp_valid  (o_rsp_valid),
        .o_rsp        (o_rsp),
        .i_rsp_credit (i_rsp_credit),
        .o_cmd_out    (o_cmd_out),
        .o_cmd_oe     (o_cmd_oe),
        .i_cmd_in     (i_cmd_in)
    );

    always #20 i_clk = ~i_clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Long division by x^7 + x^3 + 1, one header bit at a time from the MSB
    function automatic crc7_t ref_crc7(input logic [HEADER_BITS-1:0] bits);
        crc7_t c;
        logic  fb;
        c = '0;
        for (int i = HEADER_BITS - 1; i >= 0; i--) begin
            fb = c[6] ^ bits[i];
            c = {c[5:0], 1'b0};
            if (fb) begin
                c = c ^ 7'h09;
            end
        end
        return c;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("failure at %0t: %s", $time, msg);
    endtask

    task automatic finish_run();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    initial begin : main
        i_clk = 1'b0;
        i_nrst = 1'b0;
        i_req_valid = 1'b0;
        i_req = '0;
        i_rsp_credit = 1'b0;
        i_cmd_in = 1'b1;
        rng_req = SEED;
        rng_card = SEED ^ 32'h5a5a0000;
        rng_cons = SEED ^ 32'h00a50000;
        // Known value for CMD0 with argument 0
        compare_value("ref_crc7 of CMD0", ref_crc7(40'h4000000000), 7'h4a);
        // Every eighth command repeats the same mix of card behaviors
        for (int i = 0; i < NUM_CMDS; i++) begin
            rng_req = xorshift32(rng_req);
            cmd_list[i].index = rng_req[5:0];
            rng_req = xorshift32(rng_req);
            cmd_list[i].arg = rng_req;
            case (i % 8)
                3: mode_list[i] = MODE_BAD_CRC;
                4: mode_list[i] = MODE_BAD_END;
                5: mode_list[i] = MODE_BAD_IDX;
                6: mode_list[i] = MODE_SILENT;
                7: mode_list[i] = MODE_NO_RSP;
                default: mode_list[i] = MODE_GOOD;
            endcase
            cmd_list[i].expect_rsp = (mode_list[i] != MODE_NO_RSP);
        end
        // CMD0 goes first and has no response
        cmd_list[0] = '0;
        mode_list[0] = MODE_NO_RSP;
        repeat (3) @(posedge i_clk);
        compare_value("o_cmd_oe", o_cmd_oe, 1'b0);
        compare_value("o_cmd_out", o_cmd_out, 1'b1);
        compare_value("o_req_credit", o_req_credit, 1'b0);
        compare_value("o_rsp_valid", o_rsp_valid, 1'b0);
        i_nrst <= 1'b1;
        while (rsp_count < NUM_CMDS) begin
            @(posedge i_clk);
        end
        repeat (5) @(posedge i_clk);
        if (exp_q.size() != 0) begin
            note_failure("expected result records were never delivered");
        end
        finish_run();
    end

    always @(posedge i_clk) begin : watchdog
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            note_failure("run hit the cycle limit before all results came back");
            finish_run();
        end
    end

    // Requester spends one credit per command and gets it back per take
    always @(posedge i_clk) begin : requester
        if (i_nrst) begin
            if (o_req_credit) begin
                if (req_credits == REQ_CREDITS) begin
                    note_failure("request credit returned with no request outstanding");
                end else begin
                    req_credits++;
                end
            end
            rng_req = xorshift32(rng_req);
            if (sent < NUM_CMDS && req_credits > 0 && rng_req[2:0] != 3'd0) begin
                i_req_valid <= 1'b1;
                i_req <= cmd_list[sent];
                sent++;
                req_credits--;
            end else begin
                i_req_valid <= 1'b0;
            end
        end
    end

    // Card collects each frame, checks it and answers as its mode says
    initial begin : card_model
        cmd_frame_t frame;
        cmd_frame_t rsp;
        cmd_rsp_t   exp_rsp;
        cmd_req_t   req;
        cmd_index_t echo;
        crc7_t      crc;
        int         mode;
        int         gap;
        int         card_idx;
        card_idx = 0;
        forever begin
            @(posedge i_clk);
            if (o_cmd_oe) begin
                frame = '0;
                for (int n = 0; n < FRAME_BITS; n++) begin
                    // The line must stay driven for the whole frame
                    if (n > 0) begin
                        @(posedge i_clk);
                        compare_value("o_cmd_oe during frame", o_cmd_oe, 1'b1);
                    end
                    frame = {frame[FRAME_BITS-2:0], o_cmd_out};
                end
                req = cmd_list[card_idx % NUM_CMDS];
                mode = mode_list[card_idx % NUM_CMDS];
                if (card_idx >= NUM_CMDS) begin
                    note_failure("command frame seen with no command outstanding");
                end
                card_idx++;
                compare_value("o_cmd_out start bit", frame[47], 1'b0);
                compare_value("o_cmd_out transmission bit", frame[46], 1'b1);
                compare_value("o_cmd_out index", frame[45:40], req.index);
                compare_value("o_cmd_out argument", frame[39:8], req.arg);
                compare_value("o_cmd_out crc7", frame[7:1],
                              ref_crc7({2'b01, req.index, req.arg}));
                compare_value("o_cmd_out end bit", frame[0], 1'b1);
                exp_rsp = '0;
                exp_rsp.index = req.index;
                exp_rsp.no_rsp = (mode == MODE_NO_RSP);
                exp_rsp.timeout = (mode == MODE_SILENT);
                // Line must drop right after the end bit
                @(posedge i_clk);
                compare_value("o_cmd_oe after end bit", o_cmd_oe, 1'b0);
                if (mode == MODE_SILENT || mode == MODE_NO_RSP) begin
                    exp_q.push_back(exp_rsp);
                end else begin
                    rng_card = xorshift32(rng_card);
                    gap = NCR_MIN + int'(rng_card % (21 - NCR_MIN));
                    rng_card = xorshift32(rng_card);
                    exp_rsp.status = rng_card;
                    rng_card = xorshift32(rng_card);
                    echo = req.index;
                    if (mode == MODE_BAD_IDX) begin
                        echo = echo ^ (6'h1 << (rng_card % 6));
                    end
                    crc = ref_crc7({2'b00, echo, exp_rsp.status});
                    if (mode == MODE_BAD_CRC) begin
                        crc = crc ^ (7'h1 << (rng_card % 7));
                    end
                    rsp = {2'b00, echo, exp_rsp.status, crc, mode != MODE_BAD_END};
                    exp_rsp.crc_err = (mode == MODE_BAD_CRC);
                    exp_rsp.frame_err = (mode == MODE_BAD_END);
                    exp_rsp.index_err = (mode == MODE_BAD_IDX);
                    exp_q.push_back(exp_rsp);
                    for (int k = 1; k < gap; k++) begin
                        @(posedge i_clk);
                        compare_value("o_cmd_oe before response", o_cmd_oe, 1'b0);
                    end
                    for (int b = FRAME_BITS - 1; b >= 0; b--) begin
                        i_cmd_in <= rsp[b];
                        @(posedge i_clk);
                        compare_value("o_cmd_oe during response", o_cmd_oe, 1'b0);
                    end
                    i_cmd_in <= 1'b1;
                end
            end
        end
    end

    // Consumer compares records in order and returns credits, with one long hold
    always @(posedge i_clk) begin : consumer
        cmd_rsp_t exp_rsp;
        if (i_nrst) begin
            if (o_rsp_valid) begin
                if (dut_rsp_credits == 0) begin
                    note_failure("result record sent while the consumer held no credits");
                end else begin
                    dut_rsp_credits--;
                end
                if (exp_q.size() == 0) begin
                    note_failure("result record arrived with no command behind it");
                end else begin
                    exp_rsp = exp_q.pop_front();
                    compare_value("o_rsp.index", o_rsp.index, exp_rsp.index);
                    compare_value("o_rsp.status", o_rsp.status, exp_rsp.status);
                    compare_value("o_rsp.no_rsp", o_rsp.no_rsp, exp_rsp.no_rsp);
                    compare_value("o_rsp.timeout", o_rsp.timeout, exp_rsp.timeout);
                    compare_value("o_rsp.crc_err", o_rsp.crc_err, exp_rsp.crc_err);
                    compare_value("o_rsp.frame_err", o_rsp.frame_err, exp_rsp.frame_err);
                    compare_value("o_rsp.index_err", o_rsp.index_err, exp_rsp.index_err);
                end
                rsp_count++;
                owed_credits++;
            end
            // The pulse driven last edge reaches the DUT at this edge
            if (i_rsp_credit) begin
                dut_rsp_credits++;
            end
            rng_cons = xorshift32(rng_cons);
            if (rsp_count >= 12 && hold_left > 0) begin
                hold_left--;
                i_rsp_credit <= 1'b0;
            end else if (owed_credits > 0 && rng_cons[1:0] != 2'd0) begin
                i_rsp_credit <= 1'b1;
                owed_credits--;
            end else begin
                i_rsp_credit <= 1'b0;
            end
        end
    end

endmodule

// ==== sources.f ====
design/sdcmd_pkg.sv
design/sdcmd_crc7.sv
design/sdcmd_decode.sv
design/sdcmd_line_engine.sv
design/sdcmd_result.sv
design/sdcmd_top.sv
verif/sdcmd_tb.sv
